// ==== logic/riscv_isa_pkg.sv ====
// rv32if opcodes, one-hot class encodings, instruction word views and decoded field record
package riscv_isa_pkg;

	// major opcodes
	// --------------------
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_ARITH_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_ARITH_REG = 7'b0110011;
	localparam logic [6:0] OPC_FLOAD     = 7'b0000111;
	localparam logic [6:0] OPC_FSTORE    = 7'b0100111;
	localparam logic [6:0] OPC_FMADD     = 7'b1000011;
	localparam logic [6:0] OPC_FMSUB     = 7'b1000111;
	localparam logic [6:0] OPC_FNMSUB    = 7'b1001011;
	localparam logic [6:0] OPC_FNMADD    = 7'b1001111;
	localparam logic [6:0] OPC_FARITH    = 7'b1010011;

	// one bit per instruction class
	// --------------------
	localparam logic [15:0] ENC_NONE      = 16'h0000;
	localparam logic [15:0] ENC_LUI       = 16'h0001;
	localparam logic [15:0] ENC_AUIPC     = 16'h0002;
	localparam logic [15:0] ENC_JAL       = 16'h0004;
	localparam logic [15:0] ENC_JALR      = 16'h0008;
	localparam logic [15:0] ENC_LOAD      = 16'h0010;
	localparam logic [15:0] ENC_ARITH_IMM = 16'h0020;
	localparam logic [15:0] ENC_BRANCH    = 16'h0040;
	localparam logic [15:0] ENC_STORE     = 16'h0080;
	localparam logic [15:0] ENC_ARITH_REG = 16'h0100;
	localparam logic [15:0] ENC_FLOAD     = 16'h0200;
	localparam logic [15:0] ENC_FSTORE    = 16'h0400;
	localparam logic [15:0] ENC_FMADD     = 16'h0800;
	localparam logic [15:0] ENC_FMSUB     = 16'h1000;
	localparam logic [15:0] ENC_FNMADD    = 16'h2000;
	localparam logic [15:0] ENC_FNMSUB    = 16'h4000;
	localparam logic [15:0] ENC_FARITH    = 16'h8000;

	// register layout, fsrc3 doubles as func5 and rm as func3
	typedef struct packed {
		logic [4:0] fsrc3;
		logic [1:0] func2;
		logic [4:0] fsrc2;
		logic [4:0] fsrc1;
		logic [2:0] rm;
		logic [4:0] fdest;
		logic [6:0] opcode;
	} r4_view_t;

	// immediate layout
	typedef struct packed {
		logic [11:0] imm_hi;
		logic [4:0]  fsrc1;
		logic [2:0]  func3;
		logic [4:0]  imm_lo;
		logic [6:0]  opcode;
	} imm_view_t;

	typedef union packed {
		r4_view_t  r4;
		imm_view_t imm;
	} instr_word_u;

	typedef struct packed {
		logic [6:0] func7;
		logic [4:0] func5;
		logic [2:0] func3;
		logic [2:0] rm;
		logic [4:0] fsrc3;
		logic [4:0] fsrc2;
		logic [4:0] fsrc1;
		logic [4:0] fdest;
	} dec_fields_t;

endpackage

// ==== logic/decode_cfg_pkg.sv ====
// lane count, queue depth, credit counts and derived counter widths of the decode cluster
package decode_cfg_pkg;

	// lanes and queues
	// --------------------
	localparam int NUM_LANES  = 3;
	localparam int LANE_DEPTH = 2;

	// credit loops
	// --------------------
	localparam int IN_CREDITS  = NUM_LANES * LANE_DEPTH;
	localparam int OUT_CREDITS = 4;

	// widths
	// --------------------
	localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int LANE_PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;

	// wide enough for lane occupancy and the downstream credit count
	localparam int CREDIT_W =
		$clog2(((LANE_DEPTH > OUT_CREDITS) ? LANE_DEPTH : OUT_CREDITS) + 1);

endpackage

// ==== logic/lane_out_if.sv ====
// lane head to collector interface with lane and collector modports
`timescale 1ns/100ps

interface lane_out_if;

	logic                       head_valid;
	logic [15:0]                encoding;
	riscv_isa_pkg::dec_fields_t fields;
	logic [31:0]                imm32;
	logic                       exception;
	// one cycle per consumed head word
	logic                       pop;

	modport lane (
		output head_valid,
		output encoding,
		output fields,
		output imm32,
		output exception,
		input  pop
	);

	modport collector (
		input  head_valid,
		input  encoding,
		input  fields,
		input  imm32,
		input  exception,
		output pop
	);

endinterface

// ==== logic/instr_decode.sv ====
// combinational rv32if decoder producing class, fields, immediate and exception
`timescale 1ns/100ps

module instr_decode (
	input  logic [31:0]                instr_i,
	output logic [15:0]                encoding_o,
	output riscv_isa_pkg::dec_fields_t fields_o,
	output logic [31:0]                imm32_o,
	output logic                       exception_o
);

	riscv_isa_pkg::instr_word_u word;
	logic [31:0] imm_i_form;
	logic [31:0] imm_s_form;
	logic [31:0] imm_b_form;
	logic [31:0] imm_u_form;
	logic [31:0] imm_j_form;

	assign word = instr_i;

	// immediate forms
	// --------------------
	assign imm_i_form = {{20{word.imm.imm_hi[11]}}, word.imm.imm_hi};
	assign imm_s_form = {{20{word.imm.imm_hi[11]}}, word.imm.imm_hi[11:5], word.imm.imm_lo};
	assign imm_b_form = {{19{word.imm.imm_hi[11]}}, word.imm.imm_hi[11], word.imm.imm_lo[0],
		word.imm.imm_hi[10:5], word.imm.imm_lo[4:1], 1'b0};
	assign imm_u_form = {word.imm.imm_hi, word.imm.fsrc1, word.imm.func3, 12'h000};
	// j form picks bits 19:12 straight out of fsrc1 and func3
	assign imm_j_form = {{11{word.imm.imm_hi[11]}}, word.imm.imm_hi[11], word.imm.fsrc1,
		word.imm.func3, word.imm.imm_hi[0], word.imm.imm_hi[10:1], 1'b0};

	// decode by opcode
	// --------------------
	always_comb begin
		encoding_o  = riscv_isa_pkg::ENC_NONE;
		fields_o    = '0;
		imm32_o     = '0;
		exception_o = 1'b0;

		case (word.r4.opcode)
			riscv_isa_pkg::OPC_LUI,
			riscv_isa_pkg::OPC_AUIPC: begin
				encoding_o = (word.r4.opcode == riscv_isa_pkg::OPC_LUI) ?
					riscv_isa_pkg::ENC_LUI : riscv_isa_pkg::ENC_AUIPC;
				fields_o.fdest = word.r4.fdest;
				imm32_o        = imm_u_form;
			end
			riscv_isa_pkg::OPC_JAL: begin
				encoding_o     = riscv_isa_pkg::ENC_JAL;
				fields_o.fdest = word.r4.fdest;
				imm32_o        = imm_j_form;
			end
			riscv_isa_pkg::OPC_JALR: begin
				encoding_o     = riscv_isa_pkg::ENC_JALR;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.fdest = word.r4.fdest;
				imm32_o        = imm_i_form;
			end
			riscv_isa_pkg::OPC_LOAD,
			riscv_isa_pkg::OPC_ARITH_IMM: begin
				encoding_o = (word.r4.opcode == riscv_isa_pkg::OPC_LOAD) ?
					riscv_isa_pkg::ENC_LOAD : riscv_isa_pkg::ENC_ARITH_IMM;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.func3 = word.r4.rm;
				fields_o.fdest = word.r4.fdest;
				imm32_o        = imm_i_form;
			end
			riscv_isa_pkg::OPC_BRANCH,
			riscv_isa_pkg::OPC_STORE: begin
				encoding_o = (word.r4.opcode == riscv_isa_pkg::OPC_BRANCH) ?
					riscv_isa_pkg::ENC_BRANCH : riscv_isa_pkg::ENC_STORE;
				fields_o.fsrc2 = word.r4.fsrc2;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.func3 = word.r4.rm;
				imm32_o = (word.r4.opcode == riscv_isa_pkg::OPC_BRANCH) ? imm_b_form : imm_s_form;
			end
			riscv_isa_pkg::OPC_ARITH_REG: begin
				encoding_o     = riscv_isa_pkg::ENC_ARITH_REG;
				fields_o.func7 = {word.r4.fsrc3, word.r4.func2};
				fields_o.fsrc2 = word.r4.fsrc2;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.func3 = word.r4.rm;
				fields_o.fdest = word.r4.fdest;
			end
			// single precision memory
			riscv_isa_pkg::OPC_FLOAD: begin
				encoding_o     = riscv_isa_pkg::ENC_FLOAD;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.fdest = word.r4.fdest;
				imm32_o        = imm_i_form;
			end
			riscv_isa_pkg::OPC_FSTORE: begin
				encoding_o     = riscv_isa_pkg::ENC_FSTORE;
				fields_o.fsrc2 = word.r4.fsrc2;
				fields_o.fsrc1 = word.r4.fsrc1;
				imm32_o        = imm_s_form;
			end
			// fused multiply-add family, three sources and a rounding mode
			riscv_isa_pkg::OPC_FMADD,
			riscv_isa_pkg::OPC_FMSUB,
			riscv_isa_pkg::OPC_FNMADD,
			riscv_isa_pkg::OPC_FNMSUB: begin
				case (word.r4.opcode)
					riscv_isa_pkg::OPC_FMADD:  encoding_o = riscv_isa_pkg::ENC_FMADD;
					riscv_isa_pkg::OPC_FMSUB:  encoding_o = riscv_isa_pkg::ENC_FMSUB;
					riscv_isa_pkg::OPC_FNMADD: encoding_o = riscv_isa_pkg::ENC_FNMADD;
					default:                   encoding_o = riscv_isa_pkg::ENC_FNMSUB;
				endcase
				fields_o.fsrc3 = word.r4.fsrc3;
				fields_o.fsrc2 = word.r4.fsrc2;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.rm    = word.r4.rm;
				fields_o.fdest = word.r4.fdest;
			end
			riscv_isa_pkg::OPC_FARITH: begin
				encoding_o     = riscv_isa_pkg::ENC_FARITH;
				fields_o.func5 = word.r4.fsrc3;
				fields_o.fsrc2 = word.r4.fsrc2;
				fields_o.fsrc1 = word.r4.fsrc1;
				fields_o.rm    = word.r4.rm;
				fields_o.fdest = word.r4.fdest;
			end
			// unknown opcode
			default: begin
				exception_o = 1'b1;
			end
		endcase
	end

endmodule

// ==== logic/decode_lane.sv ====
// decode lane: raw word queue with its head decoded and a credit per pop
`timescale 1ns/100ps

module decode_lane (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        push_i,
	input  logic [31:0] instr_i,
	output logic        credit_o,
	lane_out_if.lane    lane_o
);

	localparam int PTR_W = decode_cfg_pkg::LANE_PTR_W;
	localparam int CNT_W = decode_cfg_pkg::CREDIT_W;

	logic [31:0]      queue_mem [decode_cfg_pkg::LANE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// queue
	// --------------------
	always_ff @(posedge clk_i) begin
		if (push_i) begin
			queue_mem[wr_ptr] <= instr_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= (wr_ptr == PTR_W'(decode_cfg_pkg::LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (lane_o.pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(decode_cfg_pkg::LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_i, lane_o.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign lane_o.head_valid = (count != '0);

	// every pop frees one entry upstream
	assign credit_o = lane_o.pop;

	// head decode
	// --------------------
	instr_decode u_instr_decode (
		.instr_i     (queue_mem[rd_ptr]),
		.encoding_o  (lane_o.encoding),
		.fields_o    (lane_o.fields),
		.imm32_o     (lane_o.imm32),
		.exception_o (lane_o.exception)
	);

	// dispatcher credits must keep pushes off a full lane
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_i |-> (count != CNT_W'(decode_cfg_pkg::LANE_DEPTH)))
		else $error("push into full lane queue");

	// collector only pops a valid head
	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lane_o.pop |-> (count != '0))
		else $error("pop from empty lane queue");

endmodule

// ==== logic/lane_dispatch.sv ====
// input register, rotating lane steering, per-lane credit counters and upstream credit return
`timescale 1ns/100ps

module lane_dispatch (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	input  logic                                 instr_valid_i,
	input  logic [31:0]                          instr_i,
	input  logic [decode_cfg_pkg::NUM_LANES-1:0] lane_credit_i,
	output logic [decode_cfg_pkg::NUM_LANES-1:0] lane_push_o,
	output logic [31:0]                          lane_instr_o,
	output logic                                 in_credit_o
);

	localparam int IDX_W = decode_cfg_pkg::LANE_IDX_W;
	localparam int CNT_W = decode_cfg_pkg::CREDIT_W;

	logic             valid_q;
	logic [31:0]      instr_q;
	logic [IDX_W-1:0] wr_ptr;
	logic [CNT_W-1:0] lane_cnt [decode_cfg_pkg::NUM_LANES];

	// input stage
	// --------------------
	always_ff @(posedge clk_i) begin
		instr_q <= instr_i;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_q     <= 1'b0;
			in_credit_o <= 1'b0;
		end else begin
			valid_q     <= instr_valid_i;
			// at most one pop per cycle, so one credit at most
			in_credit_o <= |lane_credit_i;
		end
	end

	// steering
	// --------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
		end else if (valid_q) begin
			wr_ptr <= (wr_ptr == IDX_W'(decode_cfg_pkg::NUM_LANES - 1)) ? '0 : wr_ptr + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < decode_cfg_pkg::NUM_LANES; i++) begin
			lane_push_o[i] = valid_q && (wr_ptr == IDX_W'(i));
		end
	end

	assign lane_instr_o = instr_q;

	// free entries per lane
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < decode_cfg_pkg::NUM_LANES; i++) begin
			if (!rst_n_i) begin
				lane_cnt[i] <= CNT_W'(decode_cfg_pkg::LANE_DEPTH);
			end else begin
				case ({lane_push_o[i], lane_credit_i[i]})
					2'b10:   lane_cnt[i] <= lane_cnt[i] - 1'b1;
					2'b01:   lane_cnt[i] <= lane_cnt[i] + 1'b1;
					default: lane_cnt[i] <= lane_cnt[i];
				endcase
			end
		end
	end

	// rotation on both sides keeps the write lane among the emptiest
	a_push_has_room: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		valid_q |-> (lane_cnt[wr_ptr] != '0))
		else $error("push steered to lane without free entry");

endmodule

// ==== logic/lane_collect.sv ====
// in-order rotating lane drain with downstream credit counter and registered output record
`timescale 1ns/100ps

module lane_collect (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       out_credit_i,
	lane_out_if.collector              lane_i [decode_cfg_pkg::NUM_LANES],
	output logic                       dec_valid_o,
	output logic [15:0]                dec_encoding_o,
	output riscv_isa_pkg::dec_fields_t dec_fields_o,
	output logic [31:0]                dec_imm32_o,
	output logic                       dec_exception_o
);

	localparam int IDX_W = decode_cfg_pkg::LANE_IDX_W;
	localparam int CNT_W = decode_cfg_pkg::CREDIT_W;

	logic [decode_cfg_pkg::NUM_LANES-1:0] head_valid;
	logic [decode_cfg_pkg::NUM_LANES-1:0] head_exc;
	logic [15:0]                          head_enc [decode_cfg_pkg::NUM_LANES];
	riscv_isa_pkg::dec_fields_t           head_fld [decode_cfg_pkg::NUM_LANES];
	logic [31:0]                          head_imm [decode_cfg_pkg::NUM_LANES];
	logic [IDX_W-1:0]                     rd_ptr;
	logic [CNT_W-1:0]                     out_cnt;
	logic                                 pop;

	// flatten the lane heads so the read pointer can index them
	for (genvar g = 0; g < decode_cfg_pkg::NUM_LANES; g++) begin : g_head
		assign head_valid[g] = lane_i[g].head_valid;
		assign head_exc[g]   = lane_i[g].exception;
		assign head_enc[g]   = lane_i[g].encoding;
		assign head_fld[g]   = lane_i[g].fields;
		assign head_imm[g]   = lane_i[g].imm32;
		assign lane_i[g].pop = pop && (rd_ptr == IDX_W'(g));
	end

	assign pop = head_valid[rd_ptr] && (out_cnt != '0);

	// rotation and credits
	// --------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rd_ptr      <= '0;
			out_cnt     <= CNT_W'(decode_cfg_pkg::OUT_CREDITS);
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= pop;
			if (pop) begin
				rd_ptr <= (rd_ptr == IDX_W'(decode_cfg_pkg::NUM_LANES - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({pop, out_credit_i})
				2'b10:   out_cnt <= out_cnt - 1'b1;
				2'b01:   out_cnt <= out_cnt + 1'b1;
				default: out_cnt <= out_cnt;
			endcase
		end
	end

	// output record
	// --------------------
	always_ff @(posedge clk_i) begin
		if (pop) begin
			dec_encoding_o  <= head_enc[rd_ptr];
			dec_fields_o    <= head_fld[rd_ptr];
			dec_imm32_o     <= head_imm[rd_ptr];
			dec_exception_o <= head_exc[rd_ptr];
		end
	end

	// downstream never hands back more than it was given
	a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_cnt <= CNT_W'(decode_cfg_pkg::OUT_CREDITS))
		else $error("downstream credit count above limit");

endmodule

// ==== logic/decode_cluster.sv ====
// decode cluster top: dispatcher, generated decode lanes and in-order collector
`timescale 1ns/100ps

module decode_cluster (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        instr_valid_i,
	input  logic [31:0] instr_i,
	input  logic        out_credit_i,
	output logic        in_credit_o,
	output logic        dec_valid_o,
	output logic [15:0] dec_encoding_o,
	output logic [6:0]  dec_func7_o,
	output logic [4:0]  dec_func5_o,
	output logic [2:0]  dec_func3_o,
	output logic [2:0]  dec_rm_o,
	output logic [4:0]  dec_fsrc3_o,
	output logic [4:0]  dec_fsrc2_o,
	output logic [4:0]  dec_fsrc1_o,
	output logic [4:0]  dec_fdest_o,
	output logic [31:0] dec_imm32_o,
	output logic        dec_exception_o
);

	logic [decode_cfg_pkg::NUM_LANES-1:0] lane_push;
	logic [decode_cfg_pkg::NUM_LANES-1:0] lane_credit;
	logic [31:0]                          lane_instr;
	riscv_isa_pkg::dec_fields_t           dec_fields;

	lane_out_if lane_out [decode_cfg_pkg::NUM_LANES] ();

	lane_dispatch u_lane_dispatch (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.lane_credit_i (lane_credit),
		.lane_push_o   (lane_push),
		.lane_instr_o  (lane_instr),
		.in_credit_o   (in_credit_o)
	);

	for (genvar g = 0; g < decode_cfg_pkg::NUM_LANES; g++) begin : g_lane
		decode_lane u_decode_lane (
			.clk_i    (clk_i),
			.rst_n_i  (rst_n_i),
			.push_i   (lane_push[g]),
			.instr_i  (lane_instr),
			.credit_o (lane_credit[g]),
			.lane_o   (lane_out[g])
		);
	end

	lane_collect u_lane_collect (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.out_credit_i    (out_credit_i),
		.lane_i          (lane_out),
		.dec_valid_o     (dec_valid_o),
		.dec_encoding_o  (dec_encoding_o),
		.dec_fields_o    (dec_fields),
		.dec_imm32_o     (dec_imm32_o),
		.dec_exception_o (dec_exception_o)
	);

	// record fields out as plain ports
	assign dec_func7_o = dec_fields.func7;
	assign dec_func5_o = dec_fields.func5;
	assign dec_func3_o = dec_fields.func3;
	assign dec_rm_o    = dec_fields.rm;
	assign dec_fsrc3_o = dec_fields.fsrc3;
	assign dec_fsrc2_o = dec_fields.fsrc2;
	assign dec_fsrc1_o = dec_fields.fsrc1;
	assign dec_fdest_o = dec_fields.fdest;

endmodule

// ==== verif/decode_model.svh ====
// reference rv32if decode function and fibonacci lfsr step for the testbench
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

// instruction class from the opcode alone
function automatic logic [15:0] class_of(input logic [6:0] opc);
	case (opc)
		riscv_isa_pkg::OPC_LUI:       return riscv_isa_pkg::ENC_LUI;
		riscv_isa_pkg::OPC_AUIPC:     return riscv_isa_pkg::ENC_AUIPC;
		riscv_isa_pkg::OPC_JAL:       return riscv_isa_pkg::ENC_JAL;
		riscv_isa_pkg::OPC_JALR:      return riscv_isa_pkg::ENC_JALR;
		riscv_isa_pkg::OPC_LOAD:      return riscv_isa_pkg::ENC_LOAD;
		riscv_isa_pkg::OPC_ARITH_IMM: return riscv_isa_pkg::ENC_ARITH_IMM;
		riscv_isa_pkg::OPC_BRANCH:    return riscv_isa_pkg::ENC_BRANCH;
		riscv_isa_pkg::OPC_STORE:     return riscv_isa_pkg::ENC_STORE;
		riscv_isa_pkg::OPC_ARITH_REG: return riscv_isa_pkg::ENC_ARITH_REG;
		riscv_isa_pkg::OPC_FLOAD:     return riscv_isa_pkg::ENC_FLOAD;
		riscv_isa_pkg::OPC_FSTORE:    return riscv_isa_pkg::ENC_FSTORE;
		riscv_isa_pkg::OPC_FMADD:     return riscv_isa_pkg::ENC_FMADD;
		riscv_isa_pkg::OPC_FMSUB:     return riscv_isa_pkg::ENC_FMSUB;
		riscv_isa_pkg::OPC_FNMADD:    return riscv_isa_pkg::ENC_FNMADD;
		riscv_isa_pkg::OPC_FNMSUB:    return riscv_isa_pkg::ENC_FNMSUB;
		riscv_isa_pkg::OPC_FARITH:    return riscv_isa_pkg::ENC_FARITH;
		default:                      return riscv_isa_pkg::ENC_NONE;
	endcase
endfunction

// expected record from the standard rv32if bit positions
function automatic void decode_ref(
	input  logic [31:0]                w,
	output logic [15:0]                enc,
	output riscv_isa_pkg::dec_fields_t fld,
	output logic [31:0]                imm,
	output logic                       exc
);
	logic [15:0] fma;
	logic [15:0] no_rd;
	logic [15:0] no_rs1;
	logic [15:0] with_rs2;
	logic [15:0] with_f3;
	fma = riscv_isa_pkg::ENC_FMADD | riscv_isa_pkg::ENC_FMSUB |
		riscv_isa_pkg::ENC_FNMADD | riscv_isa_pkg::ENC_FNMSUB;
	no_rd = riscv_isa_pkg::ENC_BRANCH | riscv_isa_pkg::ENC_STORE | riscv_isa_pkg::ENC_FSTORE;
	no_rs1 = riscv_isa_pkg::ENC_LUI | riscv_isa_pkg::ENC_AUIPC | riscv_isa_pkg::ENC_JAL;
	with_rs2 = no_rd | riscv_isa_pkg::ENC_ARITH_REG | fma | riscv_isa_pkg::ENC_FARITH;
	with_f3 = riscv_isa_pkg::ENC_LOAD | riscv_isa_pkg::ENC_ARITH_IMM |
		riscv_isa_pkg::ENC_BRANCH | riscv_isa_pkg::ENC_STORE | riscv_isa_pkg::ENC_ARITH_REG;

	enc = class_of(w[6:0]);
	exc = (enc == riscv_isa_pkg::ENC_NONE);
	fld = '0;
	imm = '0;
	if (!exc && (enc & no_rd) == '0)
		fld.fdest = w[11:7];
	if (!exc && (enc & no_rs1) == '0)
		fld.fsrc1 = w[19:15];
	if ((enc & with_rs2) != '0)
		fld.fsrc2 = w[24:20];
	if ((enc & with_f3) != '0)
		fld.func3 = w[14:12];
	if ((enc & (fma | riscv_isa_pkg::ENC_FARITH)) != '0)
		fld.rm = w[14:12];
	if ((enc & fma) != '0)
		fld.fsrc3 = w[31:27];
	if (enc == riscv_isa_pkg::ENC_FARITH)
		fld.func5 = w[31:27];
	if (enc == riscv_isa_pkg::ENC_ARITH_REG)
		fld.func7 = w[31:25];

	// immediate by format
	case (enc)
		riscv_isa_pkg::ENC_LUI, riscv_isa_pkg::ENC_AUIPC:
			imm = {w[31:12], 12'h000};
		riscv_isa_pkg::ENC_JAL:
			imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		riscv_isa_pkg::ENC_BRANCH:
			imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		riscv_isa_pkg::ENC_STORE, riscv_isa_pkg::ENC_FSTORE:
			imm = {{20{w[31]}}, w[31:25], w[11:7]};
		riscv_isa_pkg::ENC_JALR, riscv_isa_pkg::ENC_LOAD,
		riscv_isa_pkg::ENC_ARITH_IMM, riscv_isa_pkg::ENC_FLOAD:
			imm = {{20{w[31]}}, w[31:20]};
		default:
			imm = '0;
	endcase
endfunction

`endif

// ==== verif/decode_cluster_tb.sv ====
// decode cluster testbench with clock, reset, credit loops, random words, scoreboard and timeout
`timescale 1ns/100ps

module decode_cluster_tb;

	localparam int NUM_WORDS = 400;
	// about twenty cycles per word is far above the credit limited rate
	localparam int MAX_CYCLES = NUM_WORDS * 20;
	localparam logic [6:0] VALID_OPCODES [16] = '{
		riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC, riscv_isa_pkg::OPC_JAL,
		riscv_isa_pkg::OPC_JALR, riscv_isa_pkg::OPC_LOAD, riscv_isa_pkg::OPC_ARITH_IMM,
		riscv_isa_pkg::OPC_BRANCH, riscv_isa_pkg::OPC_STORE, riscv_isa_pkg::OPC_ARITH_REG,
		riscv_isa_pkg::OPC_FLOAD, riscv_isa_pkg::OPC_FSTORE, riscv_isa_pkg::OPC_FMADD,
		riscv_isa_pkg::OPC_FMSUB, riscv_isa_pkg::OPC_FNMADD, riscv_isa_pkg::OPC_FNMSUB,
		riscv_isa_pkg::OPC_FARITH};

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        out_credit;
	logic        in_credit;
	logic        dec_valid;
	logic [15:0] dec_encoding;
	logic [6:0]  dec_func7;
	logic [4:0]  dec_func5;
	logic [2:0]  dec_func3;
	logic [2:0]  dec_rm;
	logic [4:0]  dec_fsrc3;
	logic [4:0]  dec_fsrc2;
	logic [4:0]  dec_fsrc1;
	logic [4:0]  dec_fdest;
	logic [31:0] dec_imm32;
	logic        dec_exception;

	logic [31:0] lfsr_state = 32'hca3d_85c7;
	logic [31:0] sent_q [$];
	logic        go = 1'b0;
	int          in_credits = decode_cfg_pkg::IN_CREDITS;
	int          credits_granted = decode_cfg_pkg::OUT_CREDITS;
	int          out_owed = 0;
	int          sent = 0;
	int          received = 0;
	int          credits_back = 0;
	int          cycle = 0;
	int          data_errors = 0;
	int          credit_errors = 0;
	int          protocol_errors = 0;

	`include "decode_model.svh"

	decode_cluster u_decode_cluster (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.instr_valid_i   (instr_valid),
		.instr_i         (instr),
		.out_credit_i    (out_credit),
		.in_credit_o     (in_credit),
		.dec_valid_o     (dec_valid),
		.dec_encoding_o  (dec_encoding),
		.dec_func7_o     (dec_func7),
		.dec_func5_o     (dec_func5),
		.dec_func3_o     (dec_func3),
		.dec_rm_o        (dec_rm),
		.dec_fsrc3_o     (dec_fsrc3),
		.dec_fsrc2_o     (dec_fsrc2),
		.dec_fsrc1_o     (dec_fsrc1),
		.dec_fdest_o     (dec_fdest),
		.dec_imm32_o     (dec_imm32),
		.dec_exception_o (dec_exception)
	);

	// random source
	// --------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// mostly known opcodes and some random ones for the exception path
	function automatic logic [31:0] make_word();
		logic [24:0] upper;
		logic [6:0]  opc;
		upper = 25'(rand_bits(25));
		if (rand_bits(3) != 0)
			opc = VALID_OPCODES[4'(rand_bits(4))];
		else
			opc = 7'(rand_bits(7));
		return {upper, opc};
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp, input logic [31:0] word);
		assert (got === exp) else begin
			data_errors++;
			$display("Error %0t: %s is %h, expected %h for word %h",
				$time, name, got, exp, word);
		end
	endtask

	task automatic compare_record(input logic [31:0] word);
		logic [15:0]                enc;
		riscv_isa_pkg::dec_fields_t fld;
		logic [31:0]                imm;
		logic                       exc;
		decode_ref(word, enc, fld, imm, exc);
		compare_field("encoding", 32'(dec_encoding), 32'(enc), word);
		compare_field("func7", 32'(dec_func7), 32'(fld.func7), word);
		compare_field("func5", 32'(dec_func5), 32'(fld.func5), word);
		compare_field("func3", 32'(dec_func3), 32'(fld.func3), word);
		compare_field("rm", 32'(dec_rm), 32'(fld.rm), word);
		compare_field("fsrc3", 32'(dec_fsrc3), 32'(fld.fsrc3), word);
		compare_field("fsrc2", 32'(dec_fsrc2), 32'(fld.fsrc2), word);
		compare_field("fsrc1", 32'(dec_fsrc1), 32'(fld.fsrc1), word);
		compare_field("fdest", 32'(dec_fdest), 32'(fld.fdest), word);
		compare_field("imm32", dec_imm32, imm, word);
		compare_field("exception", 32'(dec_exception), 32'(exc), word);
	endtask

	task automatic print_error_counts();
		$display("errors: %0d data, %0d credit, %0d protocol",
			data_errors, credit_errors, protocol_errors);
	endtask

	// clock and timeout
	// --------------------
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycle < MAX_CYCLES) begin
			@(posedge clk);
			cycle++;
		end
		$display("timeout after %0d cycles with %0d of %0d records received",
			cycle, received, NUM_WORDS);
		print_error_counts();
		$display("Testbench failed");
		$finish;
	end

	// one process drives both credit loops so the lfsr order is fixed
	initial begin
		logic [31:0] word;
		forever begin
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
			out_credit  = 1'b0;
			if (go && sent < NUM_WORDS && in_credits > 0 && rand_bits(2) != 0) begin
				word = make_word();
				instr = word;
				instr_valid = 1'b1;
				sent_q.push_back(word);
				sent++;
				in_credits--;
			end
			// downstream credits withheld in two windows
			if (!((cycle >= 150 && cycle < 250) || (cycle >= 500 && cycle < 600)) &&
				out_owed > 0 && rand_bits(1) != 0) begin
				out_credit = 1'b1;
				out_owed--;
				credits_granted++;
			end
		end
	end

	// monitor and compare
	// --------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (sent == 0) begin
				assert (!dec_valid && !in_credit) else begin
					protocol_errors++;
					$display("output pulse seen before any word was sent");
				end
			end
			if (in_credit) begin
				credits_back++;
				in_credits++;
				assert (in_credits <= decode_cfg_pkg::IN_CREDITS) else begin
					credit_errors++;
					$display("Error %0t: sender holds %0d upstream credits", $time, in_credits);
				end
			end
			if (dec_valid) begin
				received++;
				out_owed++;
				assert (received <= credits_granted) else begin
					credit_errors++;
					$display("Error %0t: record %0d exceeds %0d downstream credits",
						$time, received, credits_granted);
				end
				assert (sent_q.size() > 0) else begin
					protocol_errors++;
					$display("decoded record arrived with no word outstanding");
				end
				if (sent_q.size() > 0)
					compare_record(sent_q.pop_front());
			end
		end
	end

	// reset, run and summary
	// --------------------
	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		out_credit  = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		// idle stretch so the quiet outputs get checked
		repeat (8) @(posedge clk);
		go = 1'b1;
		while (received < NUM_WORDS)
			@(posedge clk);
		repeat (4) @(posedge clk);
		assert (credits_back == sent) else begin
			credit_errors++;
			$display("Error %0t: %0d upstream credits returned for %0d words",
				$time, credits_back, sent);
		end
		print_error_counts();
		if (data_errors + credit_errors + protocol_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== decode_cluster.f ====
+incdir+verif
logic/riscv_isa_pkg.sv
logic/decode_cfg_pkg.sv
logic/lane_out_if.sv
logic/instr_decode.sv
logic/decode_lane.sv
logic/lane_dispatch.sv
logic/lane_collect.sv
logic/decode_cluster.sv
verif/decode_cluster_tb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' decode_cluster.f) verif/decode_model.svh
SIM := obj_dir/Vdecode_cluster_tb

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then \
		exit 1; \
	fi

$(SIM): decode_cluster.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module decode_cluster_tb -f decode_cluster.f -o Vdecode_cluster_tb

clean:
	rm -rf obj_dir sim.log
